/* hw/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 dec_valid,
	input  logic [REG_SEL_W-1:0] rd_sel,
	input  logic [OPCODE_W-1:0]  alu_opc,
	input  cond_t                cond,
	input  logic [31:0]          op1,
	input  logic [31:0]          op2,
	input  logic [31:0]          imm32,
	input  logic [31:0]          pc_plus_4,
	input  kind_t                kind,
	input  logic                 mem_store,
	input  width_t               mem_width,
	input  logic                 branch_ra,
	input  logic                 is_call,
	input  logic                 update_rd,
	output logic                 ex_valid,
	output kind_t                ex_kind,
	output logic [REG_SEL_W-1:0] ex_rd,
	output logic                 ex_write,
	output logic [31:0]          ex_value,
	output logic [31:0]          ex_addr,
	output logic                 ex_taken,
	output logic                 ex_store,
	output width_t               ex_width
);

	logic flag_eq;
	logic flag_gt;
	logic is_cmp;
	logic cond_met;
	logic [31:0] alu_result;
	logic [31:0] branch_target;
	logic [31:0] value_next;
	logic [31:0] addr_next;

	assign is_cmp = (kind == KIND_ALU) && (alu_opc == OPCODE_CMP);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Shifts use the low five bits of the second operand.
	// CMP yields the difference so the record still carries something useful.
	always_comb begin
		case (alu_opc)
			OPCODE_ADD: alu_result = op1 + op2;
			OPCODE_SUB: alu_result = op1 - op2;
			OPCODE_LSL: alu_result = op1 << op2[4:0];
			OPCODE_LSR: alu_result = op1 >> op2[4:0];
			OPCODE_AND: alu_result = op1 & op2;
			OPCODE_OR: alu_result = op1 | op2;
			OPCODE_XOR: alu_result = op1 ^ op2;
			OPCODE_MOV: alu_result = op2;
			OPCODE_MOVHI: alu_result = imm32;
			OPCODE_CMP: alu_result = op1 - op2;
			default: alu_result = op1 + op2;
		endcase
	end

	// The flags persist until the next CMP and are compared signed.
	always_ff @(posedge clk) begin
		if (reset) begin
			flag_eq <= 1'b0;
			flag_gt <= 1'b0;
		end else if (dec_valid && is_cmp) begin
			flag_eq <= (op1 == op2);
			flag_gt <= ($signed(op1) > $signed(op2));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Branches and addresses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Less-than is whatever is neither equal nor greater.
	always_comb begin
		case (cond)
			COND_NE: cond_met = !flag_eq;
			COND_EQ: cond_met = flag_eq;
			COND_GT: cond_met = flag_gt;
			COND_LT: cond_met = !flag_gt && !flag_eq;
			COND_ALWAYS: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	// RET and other register-indirect branches jump to the ra value.
	assign branch_target = branch_ra ? op1 : pc_plus_4 + imm32;

	// Each record kind packs its own meaning into value and addr.
	always_comb begin
		case (kind)
			KIND_MEM: begin
				value_next = mem_store ? op2 : 32'h0;
				addr_next = op1 + imm32;
			end
			KIND_BRANCH: begin
				value_next = is_call ? pc_plus_4 : 32'h0;
				addr_next = branch_target;
			end
			default: begin
				value_next = alu_result;
				addr_next = 32'h0;
			end
		endcase
	end

	// Control half of the execute register.
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_kind <= KIND_ALU;
			ex_write <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
			ex_kind <= kind;
			ex_write <= update_rd;
		end
	end

	// Payload half.
	always_ff @(posedge clk) begin
		ex_rd <= rd_sel;
		ex_value <= value_next;
		ex_addr <= addr_next;
		ex_taken <= (kind == KIND_BRANCH) && cond_met;
		ex_store <= mem_store;
		ex_width <= mem_width;
	end

endmodule

/* hw/core_datapath.sv */
`timescale 1ns/1ps

module core_datapath
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  instr_u               in_instr,
	input  logic [31:0]          in_pc_plus_4,
	output logic                 in_credit,
	output logic                 res_valid,
	output kind_t                res_kind,
	output logic [REG_SEL_W-1:0] res_rd,
	output logic                 res_write,
	output logic [31:0]          res_value,
	output logic [31:0]          res_addr,
	output logic                 res_taken,
	output logic                 res_store,
	output width_t               res_width,
	input  logic                 out_credit
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [REG_SEL_W-1:0] ra_sel;
	logic [REG_SEL_W-1:0] rb_sel;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic wr_en;
	logic [REG_SEL_W-1:0] wr_sel;
	logic [31:0] wr_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode to execute
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic dec_valid;
	logic [REG_SEL_W-1:0] rd_sel;
	logic [OPCODE_W-1:0] alu_opc;
	cond_t cond;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] imm32;
	logic [31:0] dec_pc_plus_4;
	kind_t kind;
	logic mem_store;
	width_t mem_width;
	logic branch_ra;
	logic is_call;
	logic update_rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute to result
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic ex_valid;
	kind_t ex_kind;
	logic [REG_SEL_W-1:0] ex_rd;
	logic ex_write;
	logic [31:0] ex_value;
	logic [31:0] ex_addr;
	logic ex_taken;
	logic ex_store;
	width_t ex_width;

	// Signal names match the module ports, so only the renamed PC is spelled out.
	reg_file u_reg_file (.*);

	instr_decode u_decode (.pc_plus_4_out(dec_pc_plus_4), .*);

	alu_execute u_execute (.pc_plus_4(dec_pc_plus_4), .*);

	result_stage u_result (.*);

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  instr_u               in_instr,
	input  logic [31:0]          in_pc_plus_4,
	input  logic [31:0]          ra_data,
	input  logic [31:0]          rb_data,
	output logic [REG_SEL_W-1:0] ra_sel,
	output logic [REG_SEL_W-1:0] rb_sel,
	output logic                 dec_valid,
	output logic [REG_SEL_W-1:0] rd_sel,
	output logic [OPCODE_W-1:0]  alu_opc,
	output cond_t                cond,
	output logic [31:0]          op1,
	output logic [31:0]          op2,
	output logic [31:0]          imm32,
	output logic [31:0]          pc_plus_4_out,
	output kind_t                kind,
	output logic                 mem_store,
	output width_t               mem_width,
	output logic                 branch_ra,
	output logic                 is_call,
	output logic                 update_rd
);

	class_t cls;
	logic [OPCODE_W-1:0] opcode;
	logic is_arith;
	logic is_branch;
	logic is_mem;
	logic [31:0] imm16_sext;
	logic [31:0] imm24_sext;
	logic [31:0] imm_sel;
	logic op2_is_rb;
	cond_t cond_dec;
	width_t width_dec;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field extraction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Class and opcode sit at the same place in both views.
	assign cls = in_instr.reg_form.cls;
	assign opcode = in_instr.reg_form.opcode;

	assign is_arith = (cls == CLASS_ARITH);
	assign is_branch = (cls == CLASS_BRANCH);
	assign is_mem = (cls == CLASS_MEM);

	// RET takes its target from the link register, so ra is forced to it.
	assign ra_sel = (is_branch && opcode == OPCODE_RET) ? LINK_REG : in_instr.reg_form.ra;
	assign rb_sel = in_instr.reg_form.rb;

	// Branch offsets count words, hence the two zero bits at the bottom.
	assign imm16_sext = {{16{in_instr.reg_form.imm16[15]}}, in_instr.reg_form.imm16};
	assign imm24_sext = {{6{in_instr.br_form.offset[23]}}, in_instr.br_form.offset, 2'b00};

	// MOVHI loads the raw 16-bit immediate into the upper half of the word.
	always_comb begin
		if (is_branch) begin
			imm_sel = imm24_sext;
		end else if (is_arith && opcode == OPCODE_MOVHI) begin
			imm_sel = {in_instr.reg_form.imm16, 16'h0000};
		end else begin
			imm_sel = imm16_sext;
		end
	end

	// Stores always need rb as data, arithmetic only when bit 9 asks for it.
	assign op2_is_rb = (is_arith && in_instr.reg_form.use_rb) || is_mem;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Condition and width mapping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// B, CALL and RET fall through to an unconditional branch.
	always_comb begin
		cond_dec = COND_NONE;
		if (is_branch) begin
			case (opcode)
				OPCODE_BNE: cond_dec = COND_NE;
				OPCODE_BEQ: cond_dec = COND_EQ;
				OPCODE_BGT: cond_dec = COND_GT;
				OPCODE_BLT: cond_dec = COND_LT;
				default: cond_dec = COND_ALWAYS;
			endcase
		end
	end

	// The encoding order of widths in the opcode is reversed from width_t.
	always_comb begin
		width_dec = WIDTH_WORD;
		if (is_mem) begin
			case (opcode[1:0])
				MEM_OPC_WORD: width_dec = WIDTH_WORD;
				MEM_OPC_HALF: width_dec = WIDTH_HALF;
				MEM_OPC_BYTE: width_dec = WIDTH_BYTE;
				default: width_dec = WIDTH_BYTE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers into execute
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Control fields.
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			kind <= KIND_ALU;
			cond <= COND_NONE;
			update_rd <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
			branch_ra <= 1'b0;
		end else begin
			dec_valid <= in_valid;
			kind <= is_mem ? KIND_MEM : (is_branch ? KIND_BRANCH : KIND_ALU);
			cond <= cond_dec;
			// CMP only sets flags, and CALL writes the link register.
			update_rd <= (is_arith && opcode != OPCODE_CMP) ||
				(is_branch && opcode == OPCODE_CALL);
			mem_store <= is_mem && opcode[MEM_STORE_BIT];
			is_call <= is_branch && opcode == OPCODE_CALL;
			branch_ra <= is_branch && in_instr.br_form.spare[1];
		end
	end

	// Operands and other payload, qualified downstream by dec_valid.
	always_ff @(posedge clk) begin
		rd_sel <= (is_branch && opcode == OPCODE_CALL) ? LINK_REG : in_instr.reg_form.rd;
		alu_opc <= is_arith ? opcode : OPCODE_ADD;
		op1 <= ra_data;
		op2 <= op2_is_rb ? rb_data : imm_sel;
		imm32 <= imm_sel;
		pc_plus_4_out <= in_pc_plus_4;
		mem_width <= width_dec;
	end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int NUM_REGS = 8;
	localparam int REG_SEL_W = 3;

	// CALL saves its return address here and RET reads it back.
	localparam logic [REG_SEL_W-1:0] LINK_REG = 3'd6;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Classes and opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The class lives in instruction bits 31:30.
	typedef logic [1:0] class_t;

	localparam class_t CLASS_ARITH = 2'b00;
	localparam class_t CLASS_BRANCH = 2'b01;
	localparam class_t CLASS_MEM = 2'b10;

	// The opcode lives in bits 29:26 and is read within its class.
	localparam int OPCODE_W = 4;

	localparam logic [OPCODE_W-1:0] OPCODE_ADD = 4'h0;
	localparam logic [OPCODE_W-1:0] OPCODE_SUB = 4'h1;
	localparam logic [OPCODE_W-1:0] OPCODE_LSL = 4'h2;
	localparam logic [OPCODE_W-1:0] OPCODE_LSR = 4'h3;
	localparam logic [OPCODE_W-1:0] OPCODE_AND = 4'h4;
	localparam logic [OPCODE_W-1:0] OPCODE_OR = 4'h5;
	localparam logic [OPCODE_W-1:0] OPCODE_XOR = 4'h6;
	localparam logic [OPCODE_W-1:0] OPCODE_MOV = 4'h7;
	localparam logic [OPCODE_W-1:0] OPCODE_MOVHI = 4'h8;
	localparam logic [OPCODE_W-1:0] OPCODE_CMP = 4'h9;

	localparam logic [OPCODE_W-1:0] OPCODE_BNE = 4'h0;
	localparam logic [OPCODE_W-1:0] OPCODE_BEQ = 4'h1;
	localparam logic [OPCODE_W-1:0] OPCODE_BGT = 4'h2;
	localparam logic [OPCODE_W-1:0] OPCODE_BLT = 4'h3;
	localparam logic [OPCODE_W-1:0] OPCODE_B = 4'h4;
	localparam logic [OPCODE_W-1:0] OPCODE_CALL = 4'h5;
	localparam logic [OPCODE_W-1:0] OPCODE_RET = 4'h6;

	// For memory instructions opcode bit 2 marks a store and bits 1:0 carry the width.
	localparam int MEM_STORE_BIT = 2;
	localparam logic [1:0] MEM_OPC_WORD = 2'b00;
	localparam logic [1:0] MEM_OPC_HALF = 2'b01;
	localparam logic [1:0] MEM_OPC_BYTE = 2'b10;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Arithmetic and memory words use reg_form, branches use br_form.
	// In br_form, spare[1] (bit 25) makes the target come from ra.
	typedef union packed {
		struct packed {
			class_t cls;
			logic [OPCODE_W-1:0] opcode;
			logic [15:0] imm16;
			logic use_rb;
			logic [REG_SEL_W-1:0] rd;
			logic [REG_SEL_W-1:0] ra;
			logic [REG_SEL_W-1:0] rb;
		} reg_form;
		struct packed {
			class_t cls;
			logic [OPCODE_W-1:0] opcode;
			logic [1:0] spare;
			logic [23:0] offset;
		} br_form;
	} instr_u;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Branch conditions tested against the compare flags.
	typedef logic [2:0] cond_t;

	localparam cond_t COND_NONE = 3'd0;
	localparam cond_t COND_NE = 3'd1;
	localparam cond_t COND_EQ = 3'd2;
	localparam cond_t COND_GT = 3'd3;
	localparam cond_t COND_LT = 3'd4;
	localparam cond_t COND_ALWAYS = 3'd7;

	// Memory access width as reported in a result record.
	typedef logic [1:0] width_t;

	localparam width_t WIDTH_BYTE = 2'd0;
	localparam width_t WIDTH_HALF = 2'd1;
	localparam width_t WIDTH_WORD = 2'd2;

	// What a result record describes.
	typedef logic [1:0] kind_t;

	localparam kind_t KIND_ALU = 2'd0;
	localparam kind_t KIND_MEM = 2'd1;
	localparam kind_t KIND_BRANCH = 2'd2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Credits and the result queue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Queue depth, which equals the instruction credits handed out at reset.
	localparam int IN_CREDITS = 4;
	localparam int OUT_CREDIT_INIT = 2;

	localparam int QUEUE_PTR_W = $clog2(IN_CREDITS);
	localparam int QUEUE_CNT_W = $clog2(IN_CREDITS + 1);
	localparam int OUT_CNT_W = $clog2(OUT_CREDIT_INIT + 1);

	// One queued record is kind, rd, write, value, addr, taken, store and width.
	localparam int REC_W = $bits(kind_t) + 3 + 1 + 32 + 32 + 1 + 1 + $bits(width_t);

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file
	import isa_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [REG_SEL_W-1:0] ra_sel,
	input  logic [REG_SEL_W-1:0] rb_sel,
	output logic [31:0]          ra_data,
	output logic [31:0]          rb_data,
	input  logic                 wr_en,
	input  logic [REG_SEL_W-1:0] wr_sel,
	input  logic [31:0]          wr_data
);

	logic [31:0] regs [NUM_REGS];

	// Both read ports are purely combinational so decode can capture the
	// operands at the same edge as the instruction fields.
	// A write landing in the same cycle shows up only after the edge.
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	// The single write port is driven by the result stage.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

/* hw/result_stage.sv */
`timescale 1ns/1ps

module result_stage
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ex_valid,
	input  kind_t                ex_kind,
	input  logic [REG_SEL_W-1:0] ex_rd,
	input  logic                 ex_write,
	input  logic [31:0]          ex_value,
	input  logic [31:0]          ex_addr,
	input  logic                 ex_taken,
	input  logic                 ex_store,
	input  width_t               ex_width,
	output logic                 wr_en,
	output logic [REG_SEL_W-1:0] wr_sel,
	output logic [31:0]          wr_data,
	output logic                 res_valid,
	output kind_t                res_kind,
	output logic [REG_SEL_W-1:0] res_rd,
	output logic                 res_write,
	output logic [31:0]          res_value,
	output logic [31:0]          res_addr,
	output logic                 res_taken,
	output logic                 res_store,
	output width_t               res_width,
	input  logic                 out_credit,
	output logic                 in_credit
);

	logic [REC_W-1:0] queue [IN_CREDITS];
	logic [REC_W-1:0] push_rec;
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;
	logic [OUT_CNT_W-1:0] out_credits;
	logic pop;

	// The register write happens at the same edge as the queue push.
	assign wr_en = ex_valid && ex_write;
	assign wr_sel = ex_rd;
	assign wr_data = ex_value;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result queue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Upstream credits bound the occupancy, so a push never finds it full.
	assign push_rec = {ex_kind, ex_rd, ex_write, ex_value, ex_addr, ex_taken, ex_store, ex_width};

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			queue[wr_ptr] <= push_rec;
		end
	end

	// The consumer always takes a record, so presenting one is popping it.
	assign pop = (count != '0) && (out_credits != '0);
	assign res_valid = pop;
	assign {res_kind, res_rd, res_write, res_value, res_addr, res_taken, res_store,
		res_width} = queue[rd_ptr];

	// Pointers wrap naturally because the depth is a power of two.
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_credits <= OUT_CNT_W'(OUT_CREDIT_INIT);
			in_credit <= 1'b0;
		end else begin
			if (ex_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (ex_valid && !pop) begin
				count <= count + 1'b1;
			end else if (!ex_valid && pop) begin
				count <= count - 1'b1;
			end
			// A returned credit and a pop in one cycle cancel out.
			if (out_credit && !pop) begin
				out_credits <= out_credits + 1'b1;
			end else if (!out_credit && pop) begin
				out_credits <= out_credits - 1'b1;
			end
			// Each record leaving frees one slot for upstream.
			in_credit <= pop;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run the testbench, and decide the outcome from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_core_datapath \
	-o tb_core_datapath \
	&& ./obj_dir/tb_core_datapath > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

/* src.f */
+incdir+tests
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_stage.sv
hw/core_datapath.sv
tests/tb_core_datapath.sv

/* tests/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Registers and compare flags as the program sees them, updated in issue order.
logic [31:0] model_regs [NUM_REGS];
logic model_eq;
logic model_gt;

function automatic void clear_model();
	for (int i = 0; i < NUM_REGS; i++) begin
		model_regs[i] = 32'h0;
	end
	model_eq = 1'b0;
	model_gt = 1'b0;
endfunction

// Builds the expected record for one instruction and retires it into the model.
// The record is packed as kind, rd, write, value, addr, taken, store, width.
function automatic logic [REC_W-1:0] predict_record(instr_u w, logic [31:0] pc4);
	logic [OPCODE_W-1:0] opc;
	logic [REG_SEL_W-1:0] ra;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] op2;
	kind_t kind;
	logic [REG_SEL_W-1:0] rd;
	logic wr;
	logic [31:0] value;
	logic [31:0] addr;
	logic taken;
	logic store;
	width_t width;
	opc = w.reg_form.opcode;
	// RET always reads the link register.
	ra = (w.reg_form.cls == CLASS_BRANCH && opc == OPCODE_RET) ? LINK_REG : w.reg_form.ra;
	a = model_regs[ra];
	b = model_regs[w.reg_form.rb];
	imm = {{16{w.reg_form.imm16[15]}}, w.reg_form.imm16};
	op2 = w.reg_form.use_rb ? b : imm;
	kind = KIND_ALU;
	rd = w.reg_form.rd;
	wr = 1'b0;
	value = 32'h0;
	addr = 32'h0;
	taken = 1'b0;
	store = 1'b0;
	width = WIDTH_WORD;
	if (w.reg_form.cls == CLASS_ARITH) begin
		wr = (opc != OPCODE_CMP);
		case (opc)
			OPCODE_ADD: value = a + op2;
			OPCODE_SUB: value = a - op2;
			OPCODE_LSL: value = a << op2[4:0];
			OPCODE_LSR: value = a >> op2[4:0];
			OPCODE_AND: value = a & op2;
			OPCODE_OR: value = a | op2;
			OPCODE_XOR: value = a ^ op2;
			OPCODE_MOV: value = op2;
			OPCODE_MOVHI: value = {w.reg_form.imm16, 16'h0000};
			OPCODE_CMP: begin
				value = a - op2;
				model_eq = (a == op2);
				model_gt = ($signed(a) > $signed(op2));
			end
			default: value = 32'h0;
		endcase
	end else if (w.reg_form.cls == CLASS_MEM) begin
		// Opcode bit 2 marks a store; the low bits pick word, half or byte.
		kind = KIND_MEM;
		store = opc[2];
		width = (opc[1:0] == 2'b00) ? WIDTH_WORD : ((opc[1:0] == 2'b01) ? WIDTH_HALF : WIDTH_BYTE);
		addr = a + imm;
		value = store ? b : 32'h0;
	end else begin
		kind = KIND_BRANCH;
		case (opc)
			OPCODE_BNE: taken = !model_eq;
			OPCODE_BEQ: taken = model_eq;
			OPCODE_BGT: taken = model_gt;
			OPCODE_BLT: taken = !model_gt && !model_eq;
			default: taken = 1'b1;
		endcase
		// Word offset, so the target moves in steps of four bytes.
		addr = w.br_form.spare[1] ? a :
			pc4 + {{6{w.br_form.offset[23]}}, w.br_form.offset, 2'b00};
		if (opc == OPCODE_CALL) begin
			rd = LINK_REG;
			wr = 1'b1;
			value = pc4;
		end
	end
	if (wr) begin
		model_regs[rd] = value;
	end
	return {kind, rd, wr, value, addr, taken, store, width};
endfunction

`endif

/* tests/tb_core_datapath.sv */
`timescale 1ns/1ps

module tb_core_datapath
	import isa_pkg::*, pipe_pkg::*;
();

	// Longest any single wait may take, in clock cycles.
	localparam int WAIT_LIMIT = 200;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	instr_u in_instr;
	logic [31:0] in_pc_plus_4;
	logic in_credit;
	logic res_valid;
	kind_t res_kind;
	logic [REG_SEL_W-1:0] res_rd;
	logic res_write;
	logic [31:0] res_value;
	logic [31:0] res_addr;
	logic res_taken;
	logic res_store;
	width_t res_width;
	logic out_credit = 1'b0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bookkeeping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	string test_name = "reset";
	logic [REC_W-1:0] expected [$];
	logic [31:0] pc = 32'h0000_1000;
	// Stimulus and credit delays draw from separate streams with the same seed.
	logic [31:0] stim_rng = 32'h1854;
	logic [31:0] delay_rng = 32'h1854;
	int issued = 0;
	int consumed = 0;
	int in_returned = 0;
	int out_returned = 0;
	int out_avail = 0;
	int return_delay = 0;
	logic hold_out = 1'b0;
	logic prev_res_valid = 1'b0;

	`include "core_model.svh"

	core_datapath UUT (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw_random();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	function automatic instr_u encode_reg_word(class_t cls, logic [OPCODE_W-1:0] opc,
		logic [15:0] imm, logic use_rb, logic [REG_SEL_W-1:0] rd, logic [REG_SEL_W-1:0] ra,
		logic [REG_SEL_W-1:0] rb);
		instr_u w;
		w.reg_form.cls = cls;
		w.reg_form.opcode = opc;
		w.reg_form.imm16 = imm;
		w.reg_form.use_rb = use_rb;
		w.reg_form.rd = rd;
		w.reg_form.ra = ra;
		w.reg_form.rb = rb;
		return w;
	endfunction

	function automatic instr_u encode_branch_word(logic [OPCODE_W-1:0] opc, logic [1:0] spare,
		logic [23:0] offset);
		instr_u w;
		w.br_form.cls = CLASS_BRANCH;
		w.br_form.opcode = opc;
		w.br_form.spare = spare;
		w.br_form.offset = offset;
		return w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_field(string field, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else
			abort_run($sformatf("ERROR %s %s: expected %h actual %h", test_name, field, exp, act));
	endtask

	// Only the fields that carry meaning for a record's kind are compared.
	task automatic check_record();
		logic [REC_W-1:0] rec;
		kind_t e_kind;
		logic [REG_SEL_W-1:0] e_rd;
		logic e_write;
		logic [31:0] e_value;
		logic [31:0] e_addr;
		logic e_taken;
		logic e_store;
		width_t e_width;
		if (expected.size() == 0) begin
			abort_run("a result record arrived with no instruction outstanding");
		end else begin
			rec = expected.pop_front();
			{e_kind, e_rd, e_write, e_value, e_addr, e_taken, e_store, e_width} = rec;
			check_field("kind", 32'(e_kind), 32'(res_kind));
			check_field("write", 32'(e_write), 32'(res_write));
			if (e_write) begin
				check_field("rd", 32'(e_rd), 32'(res_rd));
			end
			if (e_kind == KIND_MEM) begin
				check_field("address", e_addr, res_addr);
				check_field("store", 32'(e_store), 32'(res_store));
				check_field("width", 32'(e_width), 32'(res_width));
				if (e_store) begin
					check_field("store data", e_value, res_value);
				end
			end else if (e_kind == KIND_BRANCH) begin
				check_field("taken", 32'(e_taken), 32'(res_taken));
				check_field("target", e_addr, res_addr);
				if (e_write) begin
					check_field("link value", e_value, res_value);
				end
			end else begin
				check_field("value", e_value, res_value);
			end
		end
	endtask

	// The consumer side, sampled mid-cycle where every DUT output is settled.
	// out_avail mirrors the output credit count that the DUT should hold.
	// Every record leaving the queue returns exactly one instruction credit in the next cycle.
	always @(negedge clk) begin
		if (reset) begin
			out_avail = OUT_CREDIT_INIT;
			prev_res_valid = 1'b0;
		end else begin
			assert (in_credit === prev_res_valid) else
				abort_run("in_credit did not match a record leaving the queue");
			if (in_credit) begin
				in_returned++;
			end
			if (res_valid) begin
				assert (out_avail > 0) else
					abort_run("res_valid rose with no output credit available");
				check_record();
				consumed++;
			end
			out_avail = out_avail - (res_valid ? 1 : 0) + (out_credit ? 1 : 0);
			prev_res_valid = res_valid;
		end
	end

	// Each consumed record frees a buffer slot, which goes back after 0 to 2 cycles.
	always @(posedge clk) begin
		#1;
		out_credit = 1'b0;
		if (!reset && !hold_out && out_returned < consumed) begin
			if (return_delay > 0) begin
				return_delay--;
			end else begin
				out_credit = 1'b1;
				out_returned++;
				delay_rng = xorshift(delay_rng);
				return_delay = int'(delay_rng % 32'd3);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Driving
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Upstream may only send while it holds one of the IN_CREDITS credits.
	task automatic issue_instr(instr_u w);
		int n;
		n = 0;
		while ((IN_CREDITS - issued + in_returned) == 0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if ((IN_CREDITS - issued + in_returned) == 0) begin
			abort_run("timed out waiting for an instruction credit");
		end else begin
			in_valid = 1'b1;
			in_instr = w;
			in_pc_plus_4 = pc + 32'd4;
			expected.push_back(predict_record(w, pc + 32'd4));
			issued++;
			pc = pc + 32'd4;
			next_cycle();
			in_valid = 1'b0;
		end
	endtask

	// Waits until every record is consumed and its instruction credit came back.
	task automatic drain_results();
		int n;
		n = 0;
		while ((expected.size() != 0 || in_returned != consumed) && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (expected.size() != 0 || in_returned != consumed) begin
			abort_run("timed out waiting for outstanding result records");
		end
	endtask

	task automatic wait_consumer_credits();
		int n;
		n = 0;
		while (out_returned != consumed && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (out_returned != consumed) begin
			abort_run("timed out waiting for the consumer to return its credits");
		end
	endtask

	// Draining after each one keeps dependent instructions far enough apart.
	task automatic run_instr(instr_u w);
		issue_instr(w);
		drain_results();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic arith_ops();
		logic [31:0] rnd;
		logic [OPCODE_W-1:0] opc;
		test_name = "arith";
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'd100, 1'b0, 3'd1, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'hfff9, 1'b0, 3'd2, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_ADD, 16'h0, 1'b1, 3'd3, 3'd1, 3'd2));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_SUB, 16'd30, 1'b0, 3'd4, 3'd3, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_LSL, 16'd4, 1'b0, 3'd5, 3'd1, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_LSR, 16'd3, 1'b0, 3'd5, 3'd2, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_AND, 16'h0, 1'b1, 3'd3, 3'd2, 3'd1));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_OR, 16'h0f00, 1'b0, 3'd4, 3'd4, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_XOR, 16'h0, 1'b1, 3'd5, 3'd5, 3'd2));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOVHI, 16'habcd, 1'b0, 3'd7, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_OR, 16'h1234, 1'b0, 3'd7, 3'd7, 3'd0));
		// Random mix of ADD through MOVHI over whatever the registers hold by now.
		for (int i = 0; i < 16; i++) begin
			rnd = draw_random();
			opc = rnd[3:0] % 4'd9;
			run_instr(encode_reg_word(CLASS_ARITH, opc, rnd[31:16], rnd[4], rnd[7:5],
				rnd[10:8], rnd[13:11]));
		end
	endtask

	task automatic compare_branches();
		logic [31:0] rnd;
		test_name = "compare_branch";
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'd5, 1'b0, 3'd1, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'hfffd, 1'b0, 3'd2, 3'd0, 3'd0));
		// The register pairs give greater, equal, equal and less.
		for (int p = 0; p < 4; p++) begin
			run_instr(encode_reg_word(CLASS_ARITH, OPCODE_CMP, 16'h0, 1'b1, 3'd0,
				p[0] ? 3'd2 : 3'd1, p[1] ? 3'd1 : 3'd2));
			for (int c = 0; c < 4; c++) begin
				rnd = draw_random();
				run_instr(encode_branch_word(4'(c), 2'b00, rnd[23:0]));
			end
		end
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_CMP, 16'd5, 1'b0, 3'd0, 3'd1, 3'd0));
		run_instr(encode_branch_word(OPCODE_BEQ, 2'b00, 24'hffffff));
		run_instr(encode_branch_word(OPCODE_BLT, 2'b00, 24'h000010));
	endtask

	task automatic call_return();
		logic [31:0] rnd;
		test_name = "call_ret";
		rnd = draw_random();
		run_instr(encode_branch_word(OPCODE_B, 2'b00, rnd[23:0]));
		run_instr(encode_branch_word(OPCODE_CALL, 2'b00, 24'h000040));
		run_instr(encode_branch_word(OPCODE_CALL, 2'b00, 24'hfffff0));
		// The link register is an ordinary operand as well.
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_ADD, 16'h0008, 1'b0, 3'd1, LINK_REG, 3'd0));
		run_instr(encode_branch_word(OPCODE_RET, 2'b10, 24'h0));
	endtask

	task automatic loads_stores();
		logic [31:0] rnd;
		test_name = "load_store";
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'h1000, 1'b0, 3'd1, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOVHI, 16'hdead, 1'b0, 3'd2, 3'd0, 3'd0));
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_ADD, 16'h3eef, 1'b0, 3'd2, 3'd2, 3'd0));
		for (int s = 0; s < 2; s++) begin
			for (int wd = 0; wd < 3; wd++) begin
				rnd = draw_random();
				run_instr(encode_reg_word(CLASS_MEM, 4'(s * 4 + wd), rnd[15:0], 1'(s),
					3'd3, 3'd1, 3'd2));
			end
		end
	endtask

	task automatic credit_flow();
		logic [31:0] rnd;
		test_name = "credits";
		wait_consumer_credits();
		// Use up the consumer buffer first, so the burst has nowhere to go.
		hold_out = 1'b1;
		for (int i = 0; i < OUT_CREDIT_INIT; i++) begin
			run_instr(encode_reg_word(CLASS_ARITH, OPCODE_MOV, 16'(i + 7), 1'b0, 3'(i + 1),
				3'd0, 3'd0));
		end
		for (int i = 0; i < IN_CREDITS; i++) begin
			rnd = draw_random();
			issue_instr(encode_reg_word(CLASS_ARITH, OPCODE_ADD, rnd[15:0], 1'b0, 3'(i + 2),
				3'd1, 3'd0));
		end
		// The burst sits in the result queue while the consumer keeps its credits.
		for (int i = 0; i < 10; i++) begin
			next_cycle();
		end
		hold_out = 1'b0;
		drain_results();
		// Back to back, throttled only by the instruction credits.
		for (int i = 0; i < 2 * IN_CREDITS; i++) begin
			rnd = draw_random();
			issue_instr(encode_reg_word(CLASS_ARITH, OPCODE_XOR, rnd[15:0], 1'b0, 3'd7,
				3'(i % 5 + 1), 3'd0));
		end
		drain_results();
		wait_consumer_credits();
		run_instr(encode_reg_word(CLASS_ARITH, OPCODE_ADD, 16'h0, 1'b1, 3'd1, 3'd2, 3'd5));
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc_plus_4 = 32'h0;
		clear_model();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		arith_ops();
		compare_branches();
		call_return();
		loads_stores();
		credit_flow();
		$display("test passed");
		$finish;
	end

endmodule
